// ==== src/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // **********************************************************************
    // Core data path
    // **********************************************************************

    localparam int XLEN   = 32;
    localparam int STRB_W = XLEN / 8;        // One strobe bit per byte lane

    // Access width of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // **********************************************************************
    // AXI4 encodings
    // **********************************************************************

    localparam int AXI_ID_W = 4;

    localparam logic [AXI_ID_W-1:0] AXI_ID_LSU = '0;

    localparam logic [7:0] AXI_LEN_SINGLE  = 8'h00;    // One beat
    localparam logic [2:0] AXI_SIZE_WORD   = 3'd2;     // Four bytes per beat
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;

    // Response codes
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== src/load_extract.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_extract
    import lsu_pkg::*;
(
    input  wire  [XLEN-1:0] rdata,
    input  wire  [1:0]      offset,
    input  wire  mem_size_e size,
    input  wire             load_unsigned,
    output logic [XLEN-1:0] load_data
);

    logic [XLEN-1:0] shifted;
    logic            fill;

    // Move the addressed byte lane down to bit 0
    assign shifted = rdata >> {offset, 3'b000};

    always_comb begin
        case (size)
            size_byte: begin
                fill      = !load_unsigned && shifted[7];
                load_data = {{(XLEN-8){fill}}, shifted[7:0]};
            end
            size_half: begin
                fill      = !load_unsigned && shifted[15];
                load_data = {{(XLEN-16){fill}}, shifted[15:0]};
            end
            default: begin
                fill      = 1'b0;                   // Full word, nothing to extend
                load_data = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/lsu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_unit
    import lsu_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    // Execute side
    input  wire                 exu_valid,
    output logic                lsu_ready,
    input  wire  [XLEN-1:0]     addr,
    input  wire  [XLEN-1:0]     store_data,
    input  wire                 is_load,
    input  wire                 is_store,
    input  wire  mem_size_e     size,
    input  wire                 load_unsigned,
    // Write-back side
    input  wire                 wbu_ready,
    output logic                lsu_valid,
    output logic [XLEN-1:0]     result,
    output logic                access_fault,
    // AXI4 master
    input  wire                 awready,
    output logic                awvalid,
    output logic [XLEN-1:0]     awaddr,
    output logic [AXI_ID_W-1:0] awid,
    output logic [7:0]          awlen,
    output logic [2:0]          awsize,
    output logic [1:0]          awburst,
    input  wire                 wready,
    output logic                wvalid,
    output logic [XLEN-1:0]     wdata,
    output logic [STRB_W-1:0]   wstrb,
    output logic                wlast,
    output logic                bready,
    input  wire                 bvalid,
    input  wire  [1:0]          bresp,
    input  wire  [AXI_ID_W-1:0] bid,
    input  wire                 arready,
    output logic                arvalid,
    output logic [XLEN-1:0]     araddr,
    output logic [AXI_ID_W-1:0] arid,
    output logic [7:0]          arlen,
    output logic [2:0]          arsize,
    output logic [1:0]          arburst,
    output logic                rready,
    input  wire                 rvalid,
    input  wire  [1:0]          rresp,
    input  wire  [XLEN-1:0]     rdata,
    input  wire                 rlast,
    input  wire  [AXI_ID_W-1:0] rid
);

    typedef enum logic [1:0] {st_idle, st_pass, st_busy, st_done} state_e;

    state_e            state;
    logic              accept;
    logic [1:0]        offset;
    logic [STRB_W-1:0] store_strb;
    logic [XLEN-1:0]   store_wdata;
    logic [XLEN-1:0]   load_data;
    logic              r_err;
    logic              b_err;

    assign lsu_ready = (state == st_idle);
    assign accept    = exu_valid && lsu_ready;
    assign offset    = addr[1:0];

    // Single beat, fixed burst, word size on both address channels
    assign awid    = AXI_ID_LSU;
    assign awlen   = AXI_LEN_SINGLE;
    assign awsize  = AXI_SIZE_WORD;
    assign awburst = AXI_BURST_FIXED;
    assign wlast   = 1'b1;
    assign arid    = AXI_ID_LSU;
    assign arlen   = AXI_LEN_SINGLE;
    assign arsize  = AXI_SIZE_WORD;
    assign arburst = AXI_BURST_FIXED;

    assign r_err = (rresp != AXI_RESP_OKAY) || (rid != AXI_ID_LSU) || !rlast;
    assign b_err = (bresp != AXI_RESP_OKAY) || (bid != AXI_ID_LSU);

    // **********************************************************************
    // Store lane alignment
    // **********************************************************************

    assign store_wdata = store_data << {offset, 3'b000};

    always_comb begin
        case (size)
            size_byte: store_strb = STRB_W'(1) << offset;
            size_half: store_strb = STRB_W'(3) << offset;
            default:   store_strb = {STRB_W{1'b1}} << offset;
        endcase
    end

    load_extract load_extract_i (
        .rdata         (rdata),
        .offset        (offset),
        .size          (size),
        .load_unsigned (load_unsigned),
        .load_data     (load_data)
    );

    // **********************************************************************
    // Control FSM
    // **********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            lsu_valid    <= 1'b0;
            access_fault <= 1'b0;
            awvalid      <= 1'b0;
            wvalid       <= 1'b0;
            bready       <= 1'b0;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (is_load) begin
                            arvalid <= 1'b1;
                            state   <= st_busy;
                        end else if (is_store) begin
                            awvalid <= 1'b1;
                            state   <= st_busy;
                        end else begin
                            state <= st_pass;
                        end
                    end
                end
                st_pass: state <= st_busy;          // Address pass-through slot
                st_busy: begin
                    if (is_load) begin
                        if (arvalid && arready) begin
                            arvalid <= 1'b0;
                            rready  <= 1'b1;
                        end
                        if (rvalid && rready) begin
                            rready       <= 1'b0;
                            lsu_valid    <= 1'b1;
                            access_fault <= r_err;
                            state        <= st_done;
                        end
                    end else if (is_store) begin
                        if (awvalid && awready) begin
                            awvalid <= 1'b0;
                            wvalid  <= 1'b1;        // Data follows the address
                        end
                        if (wvalid && wready) begin
                            wvalid <= 1'b0;
                            bready <= 1'b1;
                        end
                        if (bvalid && bready) begin
                            bready       <= 1'b0;
                            lsu_valid    <= 1'b1;
                            access_fault <= b_err;
                            state        <= st_done;
                        end
                    end else begin
                        lsu_valid <= 1'b1;
                        state     <= st_done;
                    end
                end
                st_done: begin
                    if (wbu_ready) begin
                        lsu_valid    <= 1'b0;
                        access_fault <= 1'b0;
                        state        <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request and result payload
    always_ff @(posedge clk) begin
        if (accept) begin
            awaddr <= addr;
            araddr <= addr;
            wdata  <= store_wdata;
            wstrb  <= store_strb;
        end
        // Last busy cycle leaves the final value
        if (state == st_busy) begin
            result <= is_load ? load_data : addr;
        end
    end

    // A result only appears from an operation in flight
    assert property (@(posedge clk) disable iff (rst)
        $rose(lsu_valid) |-> $past(state) != st_idle);

    assert property (@(posedge clk) disable iff (rst) !(arvalid && awvalid));

endmodule

`default_nettype wire

// ==== src/axi_scratchpad.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_scratchpad
    import lsu_pkg::*;
#(
    parameter logic [XLEN-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int              MEM_WORDS = 256
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 awvalid,
    output logic                awready,
    input  wire  [XLEN-1:0]     awaddr,
    input  wire  [AXI_ID_W-1:0] awid,
    input  wire  [7:0]          awlen,
    input  wire  [2:0]          awsize,
    input  wire  [1:0]          awburst,
    input  wire                 wvalid,
    output logic                wready,
    input  wire  [XLEN-1:0]     wdata,
    input  wire  [STRB_W-1:0]   wstrb,
    input  wire                 wlast,
    output logic                bvalid,
    input  wire                 bready,
    output logic [1:0]          bresp,
    output logic [AXI_ID_W-1:0] bid,
    input  wire                 arvalid,
    output logic                arready,
    input  wire  [XLEN-1:0]     araddr,
    input  wire  [AXI_ID_W-1:0] arid,
    input  wire  [7:0]          arlen,
    input  wire  [2:0]          arsize,
    input  wire  [1:0]          arburst,
    output logic                rvalid,
    input  wire                 rready,
    output logic [XLEN-1:0]     rdata,
    output logic [1:0]          rresp,
    output logic                rlast,
    output logic [AXI_ID_W-1:0] rid
);

    localparam int              IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam logic [XLEN-1:0] MEM_BYTES = XLEN'(MEM_WORDS * 4);

    typedef enum logic [1:0] {wr_idle, wr_data, wr_resp} wr_state_e;
    typedef enum logic {rd_idle, rd_resp} rd_state_e;

    logic [XLEN-1:0]  mem [MEM_WORDS];

    wr_state_e        wr_state;
    rd_state_e        rd_state;
    logic [XLEN-1:0]  aw_off;
    logic [XLEN-1:0]  ar_off;
    logic             aw_ok;
    logic             ar_ok;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_ok;
    logic             wr_en;

    // Offsets below the base wrap high and fall out of range
    assign aw_off = awaddr - MEM_BASE;
    assign ar_off = araddr - MEM_BASE;

    assign aw_ok = (aw_off < MEM_BYTES) && (awlen == AXI_LEN_SINGLE) &&
                   (awsize == AXI_SIZE_WORD) && (awburst == AXI_BURST_FIXED);
    assign ar_ok = (ar_off < MEM_BYTES) && (arlen == AXI_LEN_SINGLE) &&
                   (arsize == AXI_SIZE_WORD) && (arburst == AXI_BURST_FIXED);

    assign awready = (wr_state == wr_idle);
    assign wready  = (wr_state == wr_data);
    assign bvalid  = (wr_state == wr_resp);
    assign arready = (rd_state == rd_idle);
    assign rvalid  = (rd_state == rd_resp);
    assign rlast   = 1'b1;

    assign wr_en = wvalid && wready && wr_ok && wlast;

    // **********************************************************************
    // Write and read channel FSMs
    // **********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_state <= wr_idle;
            rd_state <= rd_idle;
        end else begin
            case (wr_state)
                wr_idle: if (awvalid) wr_state <= wr_data;
                wr_data: if (wvalid)  wr_state <= wr_resp;
                wr_resp: if (bready)  wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
            case (rd_state)
                rd_idle: if (arvalid) rd_state <= rd_resp;
                rd_resp: if (rready)  rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_idx <= aw_off[IDX_W+1:2];
            wr_ok  <= aw_ok;
            bid    <= awid;
        end
        if (wvalid && wready) begin
            bresp <= (wr_ok && wlast) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
        if (arvalid && arready) begin
            rdata <= ar_ok ? mem[ar_off[IDX_W+1:2]] : '0;   // Out of range reads zero
            rresp <= ar_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
            rid   <= arid;
        end
    end

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wstrb[i]) mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Write data only after its address was taken
    assert property (@(posedge clk) disable iff (rst) wvalid |-> wr_state == wr_data);

endmodule

`default_nettype wire

// ==== src/lsu_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_subsys
    import lsu_pkg::*;
#(
    parameter logic [XLEN-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int              MEM_WORDS = 256
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             exu_valid,
    output logic            lsu_ready,
    input  wire  [XLEN-1:0] addr,
    input  wire  [XLEN-1:0] store_data,
    input  wire             is_load,
    input  wire             is_store,
    input  wire  mem_size_e size,
    input  wire             load_unsigned,
    input  wire             wbu_ready,
    output logic            lsu_valid,
    output logic [XLEN-1:0] result,
    output logic            access_fault
);

    // **********************************************************************
    // Internal AXI4 bus
    // **********************************************************************

    wire                awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    wire                arvalid, arready, rvalid, rready, rlast;
    wire [XLEN-1:0]     awaddr, wdata, araddr, rdata;
    wire [AXI_ID_W-1:0] awid, bid, arid, rid;
    wire [7:0]          awlen, arlen;
    wire [2:0]          awsize, arsize;
    wire [1:0]          awburst, arburst, bresp, rresp;
    wire [STRB_W-1:0]   wstrb;

    lsu_unit lsu_unit_i (
        .clk (clk), .rst (rst),
        .exu_valid (exu_valid), .lsu_ready (lsu_ready),
        .addr (addr), .store_data (store_data),
        .is_load (is_load), .is_store (is_store),
        .size (size), .load_unsigned (load_unsigned),
        .wbu_ready (wbu_ready), .lsu_valid (lsu_valid),
        .result (result), .access_fault (access_fault),
        .awready (awready), .awvalid (awvalid), .awaddr (awaddr), .awid (awid),
        .awlen (awlen), .awsize (awsize), .awburst (awburst),
        .wready (wready), .wvalid (wvalid), .wdata (wdata), .wstrb (wstrb), .wlast (wlast),
        .bready (bready), .bvalid (bvalid), .bresp (bresp), .bid (bid),
        .arready (arready), .arvalid (arvalid), .araddr (araddr), .arid (arid),
        .arlen (arlen), .arsize (arsize), .arburst (arburst),
        .rready (rready), .rvalid (rvalid), .rresp (rresp), .rdata (rdata),
        .rlast (rlast), .rid (rid)
    );

    axi_scratchpad #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) axi_scratchpad_i (
        .clk (clk), .rst (rst),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awid (awid),
        .awlen (awlen), .awsize (awsize), .awburst (awburst),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb), .wlast (wlast),
        .bvalid (bvalid), .bready (bready), .bresp (bresp), .bid (bid),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .arid (arid),
        .arlen (arlen), .arsize (arsize), .arburst (arburst),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .rlast (rlast), .rid (rid)
    );

endmodule

`default_nettype wire

// ==== verification/lsu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_checker
    import lsu_pkg::*;
#(
    parameter logic [XLEN-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int              MEM_WORDS = 256,
    parameter int              OP_LIMIT  = 40
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             exu_valid,
    input  wire             lsu_ready,
    input  wire  [XLEN-1:0] addr,
    input  wire  [XLEN-1:0] store_data,
    input  wire             is_load,
    input  wire             is_store,
    input  wire  mem_size_e size,
    input  wire             load_unsigned,
    input  wire  [127:0]    test_name,
    input  wire             wbu_ready,
    input  wire             lsu_valid,
    input  wire  [XLEN-1:0] result,
    input  wire             access_fault,
    output int              errors,
    output int              checked
);

    logic [XLEN-1:0] shadow [int unsigned];     // Word index to word value
    int              cyc = 0;
    int              acc_cyc = 0;
    logic            pending = 1'b0;
    logic            seen = 1'b0;
    logic            exp_nop;
    logic            exp_fault;
    logic            chk_result;
    logic [XLEN-1:0] exp_result;
    logic [XLEN-1:0] held_result;
    logic            held_fault;
    logic [127:0]    name;

    initial begin
        errors  = 0;
        checked = 0;
    end

    function automatic logic in_range(input logic [XLEN-1:0] a);
        return (a >= MEM_BASE) && (a < MEM_BASE + XLEN'(MEM_WORDS * 4));
    endfunction

    function automatic int lane_count(input mem_size_e sz);
        return (sz == size_byte) ? 1 : (sz == size_half) ? 2 : 4;
    endfunction

    // Shift the word down by the byte offset, keep the size, then extend
    function automatic logic [XLEN-1:0] predict_load(input logic [XLEN-1:0] a,
                                                     input mem_size_e sz,
                                                     input logic uns);
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] shifted;
        int unsigned     idx;
        idx     = (a - MEM_BASE) >> 2;
        word    = shadow.exists(idx) ? shadow[idx] : '0;
        shifted = word >> (8 * a[1:0]);
        if (sz == size_byte)
            return {{24{!uns && shifted[7]}}, shifted[7:0]};
        else if (sz == size_half)
            return {{16{!uns && shifted[15]}}, shifted[15:0]};
        return shifted;
    endfunction

    task automatic apply_store(input logic [XLEN-1:0] a, input logic [XLEN-1:0] d,
                               input mem_size_e sz);
        logic [XLEN-1:0] word;
        int unsigned     idx;
        int              off;
        int              n;
        idx  = (a - MEM_BASE) >> 2;
        off  = int'(a[1:0]);
        n    = lane_count(sz);
        word = shadow.exists(idx) ? shadow[idx] : '0;
        for (int i = 0; i < 4; i++) begin
            if (i >= off && i < off + n) word[8*i +: 8] = d[8*(i-off) +: 8];
        end
        shadow[idx] = word;
    endtask

    // Idle outputs while the reset is still applied
    always @(negedge rst) begin
        if (!lsu_ready || lsu_valid || access_fault) begin
            $display("Outputs after reset are wrong: ready %b valid %b fault %b",
                     lsu_ready, lsu_valid, access_fault);
            errors++;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cyc++;
            if (exu_valid && lsu_ready) begin
                if (pending) begin
                    $display("Operation %0s accepted while a result was pending", test_name);
                    errors++;
                end
                name       = test_name;
                acc_cyc    = cyc;
                pending    = 1'b1;
                seen       = 1'b0;
                exp_nop    = !is_load && !is_store;
                exp_fault  = !exp_nop && !in_range(addr);
                chk_result = !is_store;             // Store result is not defined
                if (is_load)
                    exp_result = in_range(addr) ? predict_load(addr, size, load_unsigned) : '0;
                else
                    exp_result = addr;
                if (is_store && in_range(addr)) apply_store(addr, store_data, size);
            end else if (pending && !seen && cyc - acc_cyc > OP_LIMIT) begin
                $display("Operation %0s was accepted but gave no result in %0d cycles",
                         name, OP_LIMIT);
                errors++;
                pending = 1'b0;
            end

            if (lsu_valid) begin
                if (!pending) begin
                    $display("Result offered with no operation accepted");
                    errors++;
                end else if (!seen) begin
                    seen = 1'b1;
                    checked++;
                    if (chk_result && result !== exp_result) begin
                        $display("mismatch %0s: expected result %h, actual %h",
                                 name, exp_result, result);
                        errors++;
                    end
                    if (access_fault !== exp_fault) begin
                        $display("mismatch %0s: expected access_fault %b, actual %b",
                                 name, exp_fault, access_fault);
                        errors++;
                    end
                    // Sampled one edge late, so a rise two edges after acceptance shows as 3
                    if (exp_nop && cyc - acc_cyc != 3) begin
                        $display("mismatch %0s: expected latency 2, actual %0d",
                                 name, cyc - acc_cyc - 1);
                        errors++;
                    end
                    held_result = result;
                    held_fault  = access_fault;
                end else if (result !== held_result || access_fault !== held_fault) begin
                    $display("Result of %0s changed while write-back stalled", name);
                    errors++;
                end
                if (wbu_ready) begin
                    pending = 1'b0;
                    seen    = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/lsu_subsys_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_subsys_tb
    import lsu_pkg::*;
;

    localparam logic [XLEN-1:0] MEM_BASE  = 32'h8000_0000;
    localparam int              MEM_WORDS = 256;
    localparam int              NUM_TESTS = 31;

    localparam logic [1:0] K_NOP   = 2'd0;
    localparam logic [1:0] K_LOAD  = 2'd1;
    localparam logic [1:0] K_STORE = 2'd2;

    typedef struct packed {
        logic [1:0]      kind;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        mem_size_e       size;
        logic            uns;
        logic [127:0]    name;
    } test_t;

    logic            clk;
    logic            rst;
    logic            exu_valid;
    logic            lsu_ready;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] store_data;
    logic            is_load;
    logic            is_store;
    mem_size_e       size;
    logic            load_unsigned;
    logic [127:0]    test_name;
    logic            wbu_ready;
    logic            lsu_valid;
    logic [XLEN-1:0] result;
    logic            access_fault;
    int              errors;
    int              checked;
    int              total;

    test_t tests [NUM_TESTS];
    int    n_added = 0;

    lsu_subsys #(.MEM_BASE(MEM_BASE), .MEM_WORDS(MEM_WORDS)) lsu_subsys_i (
        .clk (clk), .rst (rst), .exu_valid (exu_valid), .lsu_ready (lsu_ready),
        .addr (addr), .store_data (store_data), .is_load (is_load), .is_store (is_store),
        .size (size), .load_unsigned (load_unsigned), .wbu_ready (wbu_ready),
        .lsu_valid (lsu_valid), .result (result), .access_fault (access_fault)
    );

    lsu_checker #(.MEM_BASE(MEM_BASE), .MEM_WORDS(MEM_WORDS)) lsu_checker_i (
        .clk (clk), .rst (rst), .exu_valid (exu_valid), .lsu_ready (lsu_ready),
        .addr (addr), .store_data (store_data), .is_load (is_load), .is_store (is_store),
        .size (size), .load_unsigned (load_unsigned), .test_name (test_name),
        .wbu_ready (wbu_ready), .lsu_valid (lsu_valid), .result (result),
        .access_fault (access_fault), .errors (errors), .checked (checked)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Random write-back stalls in about one cycle of four
    initial begin
        void'($urandom(93));
        wbu_ready = 1'b0;
        forever begin
            @(posedge clk);
            wbu_ready <= ($urandom % 4) != 0;
        end
    end

    task automatic add_test(input logic [1:0] kind, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] d, input mem_size_e sz,
                            input logic uns, input logic [127:0] name);
        tests[n_added] = '{kind, a, d, sz, uns, name};
        n_added++;
    endtask

    // ******************************************************************
    // Stimulus table
    // ******************************************************************

    task automatic build_table();
        add_test(K_STORE, 32'h8000_0000, 32'hdead_beef, size_word, 1'b0, "sw_base");
        add_test(K_LOAD,  32'h8000_0000, 32'h0,         size_word, 1'b0, "lw_base");
        add_test(K_STORE, 32'h8000_0010, 32'h1122_3344, size_word, 1'b0, "sw_lanes");
        add_test(K_STORE, 32'h8000_0010, 32'h0000_00a5, size_byte, 1'b0, "sb_off0");
        add_test(K_STORE, 32'h8000_0011, 32'h0000_007f, size_byte, 1'b0, "sb_off1");
        add_test(K_STORE, 32'h8000_0012, 32'h0000_0080, size_byte, 1'b0, "sb_off2");
        add_test(K_STORE, 32'h8000_0013, 32'h0000_0001, size_byte, 1'b0, "sb_off3");
        add_test(K_LOAD,  32'h8000_0010, 32'h0,         size_word, 1'b0, "lw_bytes");
        add_test(K_LOAD,  32'h8000_0010, 32'h0,         size_byte, 1'b0, "lb_off0");
        add_test(K_LOAD,  32'h8000_0010, 32'h0,         size_byte, 1'b1, "lbu_off0");
        add_test(K_LOAD,  32'h8000_0012, 32'h0,         size_byte, 1'b0, "lb_off2");
        add_test(K_LOAD,  32'h8000_0013, 32'h0,         size_byte, 1'b1, "lbu_off3");
        add_test(K_STORE, 32'h8000_0020, 32'h0,         size_word, 1'b0, "sw_clear");
        add_test(K_STORE, 32'h8000_0020, 32'h0000_8001, size_half, 1'b0, "sh_off0");
        add_test(K_STORE, 32'h8000_0022, 32'h0000_7ffe, size_half, 1'b0, "sh_off2");
        add_test(K_LOAD,  32'h8000_0020, 32'h0,         size_half, 1'b0, "lh_off0");
        add_test(K_LOAD,  32'h8000_0020, 32'h0,         size_half, 1'b1, "lhu_off0");
        add_test(K_LOAD,  32'h8000_0022, 32'h0,         size_half, 1'b0, "lh_off2");
        add_test(K_LOAD,  32'h8000_0020, 32'h0,         size_word, 1'b0, "lw_halves");
        add_test(K_STORE, 32'h8000_0030, 32'hffff_ffff, size_word, 1'b0, "sw_ones");
        add_test(K_STORE, 32'h8000_0031, 32'h0000_1234, size_half, 1'b0, "sh_off1");
        add_test(K_LOAD,  32'h8000_0030, 32'h0,         size_word, 1'b0, "lw_mid_half");
        add_test(K_LOAD,  32'h8000_0031, 32'h0,         size_half, 1'b1, "lhu_off1");
        add_test(K_STORE, 32'h8000_03fc, 32'hcafe_f00d, size_word, 1'b0, "sw_top");
        add_test(K_LOAD,  32'h8000_03fc, 32'h0,         size_word, 1'b0, "lw_top");
        add_test(K_STORE, 32'h8000_0400, 32'h1234_5678, size_word, 1'b0, "sw_oob");
        add_test(K_LOAD,  32'h8000_0400, 32'h0,         size_word, 1'b0, "lw_oob");
        add_test(K_LOAD,  32'h1000_0000, 32'h0,         size_word, 1'b0, "lw_below");
        add_test(K_NOP,   32'h1234_5678, 32'h0,         size_word, 1'b0, "pass_thru");
        add_test(K_NOP,   32'h8000_0000, 32'h0,         size_word, 1'b0, "pass_base");
        add_test(K_LOAD,  32'h8000_0000, 32'h0,         size_word, 1'b0, "lw_recheck");
    endtask

    initial begin
        rst           = 1'b1;
        exu_valid     = 1'b0;
        addr          = '0;
        store_data    = '0;
        is_load       = 1'b0;
        is_store      = 1'b0;
        size          = size_word;
        load_unsigned = 1'b0;
        test_name     = '0;
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            // Held until consumed; exu_valid stays high to probe acceptance
            exu_valid     <= 1'b1;
            addr          <= tests[i].addr;
            store_data    <= tests[i].data;
            is_load       <= tests[i].kind == K_LOAD;
            is_store      <= tests[i].kind == K_STORE;
            size          <= tests[i].size;
            load_unsigned <= tests[i].uns;
            test_name     <= tests[i].name;
            @(posedge clk);
            while (!lsu_ready) @(posedge clk);
            @(posedge clk);
            while (!(lsu_valid && wbu_ready)) @(posedge clk);
        end
        exu_valid <= 1'b0;
        repeat (4) @(posedge clk);
        total = errors + ((checked != NUM_TESTS) ? 1 : 0);
        $display("Closing: %0d results checked, %0d errors", checked, total);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_TESTS * 50 * 8);
        $display("Watchdog expired before all operations completed");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_subsys.f ====
src/lsu_pkg.sv
src/load_extract.sv
src/lsu_unit.sv
src/axi_scratchpad.sv
src/lsu_subsys.sv
verification/lsu_checker.sv
verification/lsu_subsys_tb.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vlsu_subsys_tb: lsu_subsys.f $(SRCS)
	verilator --binary --timing --assert --top-module lsu_subsys_tb -f lsu_subsys.f

run: obj_dir/Vlsu_subsys_tb
	./obj_dir/Vlsu_subsys_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
